//--- hw/db_pkg.sv
// ------------------------------------------------------------
// Command and status codes and default sizes for the key-value
// table, referenced by scoped name from the RTL and testbench
// ------------------------------------------------------------

package db_pkg;

    // ------------------------------------------------------------
    // Default sizes
    // ------------------------------------------------------------
    // 64 entries
    localparam int DEFAULT_KEY_WID = 6;
    localparam int DEFAULT_VALUE_WID = 16;

    // Cycles that init_done stays low after an init pulse
    localparam int INIT_SETTLE_CYCLES = 3;

    // ------------------------------------------------------------
    // Control port codes
    // ------------------------------------------------------------
    // Code 7 is left undefined and is answered with an error
    typedef enum logic [2:0] {
        COMMAND_NOP      = 3'd0,
        COMMAND_CLEAR    = 3'd1,
        COMMAND_GET      = 3'd2,
        COMMAND_GET_NEXT = 3'd3,
        COMMAND_UNSET    = 3'd4,
        COMMAND_REPLACE  = 3'd5,
        COMMAND_SET      = 3'd6
    } command_t;

    // Reply status, valid with ack
    typedef enum logic [1:0] {
        STATUS_OK      = 2'd0,
        STATUS_ERROR   = 2'd1,
        STATUS_TIMEOUT = 2'd2
    } status_t;

endpackage : db_pkg

//--- hw/db_peripheral.sv
// ------------------------------------------------------------
// Command front end: takes one control command at a time and
// turns it into store read, write and init requests
// ------------------------------------------------------------
`timescale 1ns/1ps

module db_peripheral #(
    parameter int KEY_WID        = db_pkg::DEFAULT_KEY_WID,
    parameter int VALUE_WID      = db_pkg::DEFAULT_VALUE_WID,
    parameter int TIMEOUT_CYCLES = 0
) (
    input  logic                 clk,
    input  logic                 srst,

    // Control port
    input  logic                 req,
    input  db_pkg::command_t     command,
    input  logic [KEY_WID-1:0]   key,
    input  logic [VALUE_WID-1:0] set_value,
    output logic                 rdy,
    output logic                 ack,
    output db_pkg::status_t      status,
    output logic                 get_valid,
    output logic [KEY_WID-1:0]   get_key,
    output logic [VALUE_WID-1:0] get_value,

    // Store init
    output logic                 init,
    input  logic                 init_done,

    // Store write port
    output logic                 wr_req,
    output logic [KEY_WID-1:0]   wr_key,
    output logic                 wr_valid,
    output logic [VALUE_WID-1:0] wr_value,
    input  logic                 wr_rdy,
    input  logic                 wr_ack,

    // Store read port
    output logic                 rd_req,
    output logic [KEY_WID-1:0]   rd_key,
    output logic                 rd_next,
    input  logic                 rd_rdy,
    input  logic                 rd_ack,
    input  logic                 rd_valid,
    input  logic [VALUE_WID-1:0] rd_value,
    input  logic [KEY_WID-1:0]   rd_next_key
);

    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_WID = $clog2(DEBOUNCE_CYCLES);

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        CLEAR,
        RD,
        RMW,
        WR,
        CLEAR_PENDING,
        RD_PENDING,
        WR_PENDING,
        DONE,
        ERROR,
        TIMEOUT
    } state_t;

    state_t state;
    state_t nxt_state;

    logic reset_timer;
    logic inc_timer;
    logic timeout;
    logic accept;

    logic [DEBOUNCE_WID-1:0] debounce_cnt;
    logic init_done_debounced;

    assign accept = req && rdy;

    // ------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else if (timeout) begin
            state <= TIMEOUT;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        reset_timer = 1'b0;
        inc_timer = 1'b0;
        rdy = 1'b0;
        ack = 1'b0;
        status = db_pkg::STATUS_OK;
        init = 1'b0;
        wr_req = 1'b0;
        rd_req = 1'b0;

        case (state)
            RESET: begin
                if (init_done_debounced) begin
                    nxt_state = IDLE;
                end
            end
            IDLE: begin
                reset_timer = 1'b1;
                rdy = 1'b1;
                if (req) begin
                    case (command)
                        db_pkg::COMMAND_NOP:      nxt_state = DONE;
                        db_pkg::COMMAND_CLEAR:    nxt_state = CLEAR;
                        db_pkg::COMMAND_GET:      nxt_state = RD;
                        db_pkg::COMMAND_GET_NEXT: nxt_state = RD;
                        db_pkg::COMMAND_UNSET:    nxt_state = RMW;
                        db_pkg::COMMAND_REPLACE:  nxt_state = RMW;
                        db_pkg::COMMAND_SET:      nxt_state = WR;
                        default:                  nxt_state = ERROR;
                    endcase
                end
            end
            CLEAR: begin
                inc_timer = 1'b1;
                init = 1'b1;
                nxt_state = CLEAR_PENDING;
            end
            RD: begin
                inc_timer = 1'b1;
                rd_req = 1'b1;
                // Waits here while a cut-off scan is still running
                if (rd_rdy) begin
                    nxt_state = RD_PENDING;
                end
            end
            RMW: begin
                inc_timer = 1'b1;
                rd_req = 1'b1;
                wr_req = 1'b1;
                if (rd_rdy && wr_rdy) begin
                    nxt_state = RD_PENDING;
                end
            end
            WR: begin
                inc_timer = 1'b1;
                wr_req = 1'b1;
                if (wr_rdy) begin
                    nxt_state = WR_PENDING;
                end
            end
            CLEAR_PENDING: begin
                inc_timer = 1'b1;
                if (init_done_debounced) begin
                    nxt_state = DONE;
                end
            end
            RD_PENDING: begin
                inc_timer = 1'b1;
                if (rd_ack) begin
                    nxt_state = DONE;
                end
            end
            WR_PENDING: begin
                inc_timer = 1'b1;
                if (wr_ack) begin
                    nxt_state = DONE;
                end
            end
            DONE: begin
                ack = 1'b1;
                status = db_pkg::STATUS_OK;
                nxt_state = IDLE;
            end
            ERROR: begin
                ack = 1'b1;
                status = db_pkg::STATUS_ERROR;
                nxt_state = IDLE;
            end
            TIMEOUT: begin
                ack = 1'b1;
                status = db_pkg::STATUS_TIMEOUT;
                nxt_state = IDLE;
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Request and response latches
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_key <= key;
            rd_key <= key;
            rd_next <= (command == db_pkg::COMMAND_GET_NEXT);
            // Unset writes an empty entry
            if (command == db_pkg::COMMAND_UNSET) begin
                wr_valid <= 1'b0;
                wr_value <= '0;
            end else begin
                wr_valid <= 1'b1;
                wr_value <= set_value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            get_valid <= rd_valid;
            get_key <= rd_next_key;
            get_value <= rd_value;
        end
    end

    // Init done must hold high for several cycles before it counts
    always_ff @(posedge clk) begin
        if (srst || init) begin
            debounce_cnt <= '0;
        end else if (!init_done) begin
            debounce_cnt <= '0;
        end else if (!init_done_debounced) begin
            debounce_cnt <= debounce_cnt + 1'b1;
        end
    end

    assign init_done_debounced = (debounce_cnt == DEBOUNCE_WID'(DEBOUNCE_CYCLES - 1));

    // ------------------------------------------------------------
    // Optional command timeout
    // ------------------------------------------------------------
    generate
        if (TIMEOUT_CYCLES > 0) begin : g_timeout
            localparam int TIMER_WID = $clog2(TIMEOUT_CYCLES + 1);
            logic [TIMER_WID-1:0] timer;

            always_ff @(posedge clk) begin
                if (srst || reset_timer) begin
                    timer <= '0;
                end else if (inc_timer) begin
                    timer <= timer + 1'b1;
                end
            end

            // Only fires on a counted cycle, so the reply states leave cleanly
            assign timeout = inc_timer && (timer == TIMER_WID'(TIMEOUT_CYCLES - 1));
        end else begin : g_no_timeout
            assign timeout = 1'b0;
        end
    endgenerate

endmodule : db_peripheral

//--- hw/db_store.sv
// ------------------------------------------------------------
// Direct-indexed key-value store with one-cycle read and write,
// an upward get-next scan and a one-cycle clear
// ------------------------------------------------------------
`timescale 1ns/1ps

module db_store #(
    parameter int KEY_WID   = db_pkg::DEFAULT_KEY_WID,
    parameter int VALUE_WID = db_pkg::DEFAULT_VALUE_WID
) (
    input  logic                 clk,
    input  logic                 srst,

    // Init
    input  logic                 init,
    output logic                 init_done,

    // Write port
    input  logic                 wr_req,
    input  logic [KEY_WID-1:0]   wr_key,
    input  logic                 wr_valid,
    input  logic [VALUE_WID-1:0] wr_value,
    output logic                 wr_rdy,
    output logic                 wr_ack,

    // Read port
    input  logic                 rd_req,
    input  logic [KEY_WID-1:0]   rd_key,
    input  logic                 rd_next,
    output logic                 rd_rdy,
    output logic                 rd_ack,
    output logic                 rd_valid,
    output logic [VALUE_WID-1:0] rd_value,
    output logic [KEY_WID-1:0]   rd_next_key
);

    localparam int ENTRIES = 2 ** KEY_WID;
    localparam int SETTLE_WID = $clog2(db_pkg::INIT_SETTLE_CYCLES + 1);

    logic [ENTRIES-1:0]   valid;
    logic [VALUE_WID-1:0] mem [ENTRIES];

    logic [SETTLE_WID-1:0] settle_cnt;
    logic                  scanning;
    logic [KEY_WID-1:0]    scan_key;
    logic                  scan_hit;
    logic                  wr_take;
    logic                  rd_take;

    // Both ports stall while a scan runs
    assign wr_rdy = !scanning;
    assign rd_rdy = !scanning;
    assign wr_take = wr_req && wr_rdy;
    assign rd_take = rd_req && rd_rdy;

    assign scan_hit = valid[scan_key];

    // ------------------------------------------------------------
    // Clear and settle
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst || init) begin
            settle_cnt <= SETTLE_WID'(db_pkg::INIT_SETTLE_CYCLES);
        end else if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
        end
    end

    assign init_done = (settle_cnt == '0);

    // ------------------------------------------------------------
    // Table
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst || init) begin
            valid <= '0;
        end else if (wr_take) begin
            valid[wr_key] <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[wr_key] <= wr_value;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= wr_take;
        end
    end

    // ------------------------------------------------------------
    // Read and get-next scan
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            scanning <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= 1'b0;
            if (scanning) begin
                // Stop on the first valid entry or at the top
                if (scan_hit || (scan_key == '1)) begin
                    scanning <= 1'b0;
                    rd_ack <= 1'b1;
                end
            end else if (rd_take) begin
                // Nothing above the top key, so answer at once
                if (!rd_next || (rd_key == '1)) begin
                    rd_ack <= 1'b1;
                end else begin
                    scanning <= 1'b1;
                end
            end
        end
    end

    // Read data, only meaningful on the cycle of rd_ack
    always_ff @(posedge clk) begin
        if (scanning) begin
            scan_key <= scan_key + 1'b1;
            rd_valid <= scan_hit;
            rd_value <= scan_hit ? mem[scan_key] : '0;
            rd_next_key <= scan_hit ? scan_key : '0;
        end else if (rd_take) begin
            scan_key <= rd_key + 1'b1;
            if (rd_next) begin
                rd_valid <= 1'b0;
                rd_value <= '0;
                rd_next_key <= '0;
            end else begin
                rd_valid <= valid[rd_key];
                rd_value <= valid[rd_key] ? mem[rd_key] : '0;
                rd_next_key <= rd_key;
            end
        end
    end

endmodule : db_store

//--- hw/db_subsystem.sv
// ------------------------------------------------------------
// Top level of the key-value table: command front end and store
// ------------------------------------------------------------
`timescale 1ns/1ps

module db_subsystem #(
    parameter int KEY_WID        = db_pkg::DEFAULT_KEY_WID,
    parameter int VALUE_WID      = db_pkg::DEFAULT_VALUE_WID,
    parameter int TIMEOUT_CYCLES = 32
) (
    input  logic                 clk,
    input  logic                 srst,

    // Control port
    input  logic                 req,
    input  db_pkg::command_t     command,
    input  logic [KEY_WID-1:0]   key,
    input  logic [VALUE_WID-1:0] set_value,
    output logic                 rdy,
    output logic                 ack,
    output db_pkg::status_t      status,
    output logic                 get_valid,
    output logic [KEY_WID-1:0]   get_key,
    output logic [VALUE_WID-1:0] get_value
);

    // Init
    logic init;
    logic init_done;

    // Write port
    logic                 wr_req;
    logic [KEY_WID-1:0]   wr_key;
    logic                 wr_valid;
    logic [VALUE_WID-1:0] wr_value;
    logic                 wr_rdy;
    logic                 wr_ack;

    // Read port
    logic                 rd_req;
    logic [KEY_WID-1:0]   rd_key;
    logic                 rd_next;
    logic                 rd_rdy;
    logic                 rd_ack;
    logic                 rd_valid;
    logic [VALUE_WID-1:0] rd_value;
    logic [KEY_WID-1:0]   rd_next_key;

    db_peripheral #(
        .KEY_WID        (KEY_WID),
        .VALUE_WID      (VALUE_WID),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_peripheral (
        .clk         (clk),
        .srst        (srst),
        .req         (req),
        .command     (command),
        .key         (key),
        .set_value   (set_value),
        .rdy         (rdy),
        .ack         (ack),
        .status      (status),
        .get_valid   (get_valid),
        .get_key     (get_key),
        .get_value   (get_value),
        .init        (init),
        .init_done   (init_done),
        .wr_req      (wr_req),
        .wr_key      (wr_key),
        .wr_valid    (wr_valid),
        .wr_value    (wr_value),
        .wr_rdy      (wr_rdy),
        .wr_ack      (wr_ack),
        .rd_req      (rd_req),
        .rd_key      (rd_key),
        .rd_next     (rd_next),
        .rd_rdy      (rd_rdy),
        .rd_ack      (rd_ack),
        .rd_valid    (rd_valid),
        .rd_value    (rd_value),
        .rd_next_key (rd_next_key)
    );

    db_store #(
        .KEY_WID   (KEY_WID),
        .VALUE_WID (VALUE_WID)
    ) u_store (
        .clk         (clk),
        .srst        (srst),
        .init        (init),
        .init_done   (init_done),
        .wr_req      (wr_req),
        .wr_key      (wr_key),
        .wr_valid    (wr_valid),
        .wr_value    (wr_value),
        .wr_rdy      (wr_rdy),
        .wr_ack      (wr_ack),
        .rd_req      (rd_req),
        .rd_key      (rd_key),
        .rd_next     (rd_next),
        .rd_rdy      (rd_rdy),
        .rd_ack      (rd_ack),
        .rd_valid    (rd_valid),
        .rd_value    (rd_value),
        .rd_next_key (rd_next_key)
    );

endmodule : db_subsystem

//--- tb/db_subsystem_assertions.sv
// ------------------------------------------------------------
// Concurrent checks on the control handshake, bound into the top
// ------------------------------------------------------------
`timescale 1ns/1ps

module db_subsystem_assertions (
    input logic clk,
    input logic srst,
    input logic rdy,
    input logic ack
);

    // ack is a single-cycle pulse
    ack_single_pulse: assert property (
        @(posedge clk) disable iff (srst) ack |=> !ack
    ) else $error("ack stayed high on two cycles in a row");

    // No new command is offered while a reply is out
    rdy_low_with_ack: assert property (
        @(posedge clk) disable iff (srst) ack |-> !rdy
    ) else $error("rdy was high together with ack");

    // Control port stays closed through reset
    rdy_low_in_reset: assert property (
        @(posedge clk) srst |=> !rdy
    ) else $error("rdy was high while srst was asserted");

endmodule : db_subsystem_assertions

//--- tb/db_subsystem_tb.sv
// ------------------------------------------------------------
// Testbench for the key-value table that checks random commands
// against a reference table and runs as the simulation top
// ------------------------------------------------------------
`timescale 1ns/1ps

module db_subsystem_tb;

    localparam int KEY_WID = db_pkg::DEFAULT_KEY_WID;
    localparam int VALUE_WID = db_pkg::DEFAULT_VALUE_WID;
    localparam int TIMEOUT_CYCLES = 32;
    localparam int ENTRIES = 2 ** KEY_WID;
    // Scan lengths whose outcome is certain
    localparam int SAFE_SCAN = 16;
    localparam int SURE_TIMEOUT_SCAN = 40;
    localparam int WAIT_LIMIT = 100;

    logic                 clk = 1'b0;
    logic                 srst;
    logic                 req;
    db_pkg::command_t     command;
    logic [KEY_WID-1:0]   key;
    logic [VALUE_WID-1:0] set_value;
    logic                 rdy;
    logic                 ack;
    db_pkg::status_t      status;
    logic                 get_valid;
    logic [KEY_WID-1:0]   get_key;
    logic [VALUE_WID-1:0] get_value;

    // Reply captured on the ack cycle
    db_pkg::status_t      got_status;
    logic                 got_valid;
    logic [KEY_WID-1:0]   got_key;
    logic [VALUE_WID-1:0] got_value;

    // Reference table that keeps the value at zero while an entry is invalid
    logic                 model_valid [ENTRIES];
    logic [VALUE_WID-1:0] model_value [ENTRIES];

    integer seed;
    string  test_name;
    int     status_errors;
    int     get_errors;
    int     wait_timeouts;

    db_subsystem #(
        .KEY_WID        (KEY_WID),
        .VALUE_WID      (VALUE_WID),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_dut (
        .clk       (clk),
        .srst      (srst),
        .req       (req),
        .command   (command),
        .key       (key),
        .set_value (set_value),
        .rdy       (rdy),
        .ack       (ack),
        .status    (status),
        .get_valid (get_valid),
        .get_key   (get_key),
        .get_value (get_value)
    );

    bind db_subsystem db_subsystem_assertions u_assertions (
        .clk  (clk),
        .srst (srst),
        .rdy  (rdy),
        .ack  (ack)
    );

    always begin
        #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random draws and run control
    // ------------------------------------------------------------
    function automatic int rand_below(input int limit);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % limit);
    endfunction

    function automatic logic [KEY_WID-1:0] rand_key();
        return KEY_WID'(rand_below(ENTRIES));
    endfunction

    function automatic logic [VALUE_WID-1:0] rand_value();
        logic [31:0] r;
        r = $random(seed);
        return r[VALUE_WID-1:0];
    endfunction

    task automatic finish_run();
        $display("Summary: %0d status errors, %0d get errors, %0d wait timeouts",
                 status_errors, get_errors, wait_timeouts);
        if (status_errors + get_errors + wait_timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rdy !== 1'b1 && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (rdy !== 1'b1) begin
            $display("%s: rdy did not rise within %0d cycles", test_name, WAIT_LIMIT);
            wait_timeouts++;
            finish_run();
        end
    endtask

    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack !== 1'b1 && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk);
        end
        if (ack !== 1'b1) begin
            $display("%s: no ack within %0d cycles of the command", test_name, WAIT_LIMIT);
            wait_timeouts++;
            finish_run();
        end else begin
            got_status = status;
            got_valid = get_valid;
            got_key = get_key;
            got_value = get_value;
        end
    endtask

    // One command from offer to reply
    task automatic issue(input db_pkg::command_t cmd, input logic [KEY_WID-1:0] k,
                         input logic [VALUE_WID-1:0] v);
        wait_ready();
        @(posedge clk);
        req <= 1'b1;
        command <= cmd;
        key <= k;
        set_value <= v;
        @(posedge clk);
        req <= 1'b0;
        wait_ack();
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_status(input db_pkg::status_t expected, input db_pkg::status_t actual);
        if (actual !== expected) begin
            status_errors++;
            $display("error %s: status expected %s actual %s (%0d)",
                     test_name, expected.name(), actual.name(), actual);
        end
    endtask

    task automatic check_get(input logic exp_valid, input logic [KEY_WID-1:0] exp_key,
                             input logic [VALUE_WID-1:0] exp_value, input logic act_valid,
                             input logic [KEY_WID-1:0] act_key,
                             input logic [VALUE_WID-1:0] act_value);
        if (act_valid !== exp_valid || act_key !== exp_key || act_value !== exp_value) begin
            get_errors++;
            $display(
                "error %s: expected valid=%0b key=%0d value=%h, actual valid=%0b key=%0d value=%h",
                test_name, exp_valid, exp_key, exp_value, act_valid, act_key, act_value);
        end
    endtask

    // ------------------------------------------------------------
    // Commands with model update
    // ------------------------------------------------------------
    task automatic set_entry(input logic [KEY_WID-1:0] k, input logic [VALUE_WID-1:0] v);
        issue(db_pkg::COMMAND_SET, k, v);
        check_status(db_pkg::STATUS_OK, got_status);
        model_valid[k] = 1'b1;
        model_value[k] = v;
    endtask

    task automatic get_entry(input logic [KEY_WID-1:0] k);
        issue(db_pkg::COMMAND_GET, k, '0);
        check_status(db_pkg::STATUS_OK, got_status);
        check_get(model_valid[k], k, model_value[k], got_valid, got_key, got_value);
    endtask

    // Replace and unset answer with the old entry
    task automatic replace_entry(input logic [KEY_WID-1:0] k, input logic [VALUE_WID-1:0] v);
        issue(db_pkg::COMMAND_REPLACE, k, v);
        check_status(db_pkg::STATUS_OK, got_status);
        check_get(model_valid[k], k, model_value[k], got_valid, got_key, got_value);
        model_valid[k] = 1'b1;
        model_value[k] = v;
    endtask

    task automatic unset_entry(input logic [KEY_WID-1:0] k);
        issue(db_pkg::COMMAND_UNSET, k, rand_value());
        check_status(db_pkg::STATUS_OK, got_status);
        check_get(model_valid[k], k, model_value[k], got_valid, got_key, got_value);
        model_valid[k] = 1'b0;
        model_value[k] = '0;
    endtask

    task automatic clear_table();
        int i;
        issue(db_pkg::COMMAND_CLEAR, rand_key(), rand_value());
        check_status(db_pkg::STATUS_OK, got_status);
        for (i = 0; i < ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_value[i] = '0;
        end
    endtask

    task automatic send_nop(input logic [KEY_WID-1:0] k);
        issue(db_pkg::COMMAND_NOP, k, rand_value());
        check_status(db_pkg::STATUS_OK, got_status);
    endtask

    task automatic send_undefined(input logic [KEY_WID-1:0] k);
        logic [2:0] code;
        code = 3'd7;
        issue(db_pkg::command_t'(code), k, rand_value());
        check_status(db_pkg::STATUS_ERROR, got_status);
    endtask

    // First valid key above start, and how many entries the scan examines
    task automatic find_next(input int start, output logic found, output int next,
                             output int scanned);
        int i;
        found = 1'b0;
        next = 0;
        scanned = ENTRIES - 1 - start;
        for (i = start + 1; i < ENTRIES; i++) begin
            if (!found && model_valid[i]) begin
                found = 1'b1;
                next = i;
                scanned = i - start;
            end
        end
    endtask

    // Scans of uncertain outcome fall back to a plain get
    task automatic get_next_entry(input logic [KEY_WID-1:0] k);
        logic found;
        int   next;
        int   scanned;
        find_next(int'(k), found, next, scanned);
        if (scanned > SAFE_SCAN && scanned < SURE_TIMEOUT_SCAN) begin
            get_entry(k);
        end else begin
            issue(db_pkg::COMMAND_GET_NEXT, k, '0);
            if (scanned <= SAFE_SCAN) begin
                check_status(db_pkg::STATUS_OK, got_status);
                check_get(found, KEY_WID'(next), found ? model_value[next] : '0,
                          got_valid, got_key, got_value);
            end else begin
                check_status(db_pkg::STATUS_TIMEOUT, got_status);
                // Back-pressure must hold this get until the scan ends
                get_entry(k);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int                 op;
        int                 base;
        int                 i;
        logic [KEY_WID-1:0] k;

        seed = 83;
        srst = 1'b1;
        req = 1'b0;
        command = db_pkg::COMMAND_NOP;
        key = '0;
        set_value = '0;
        status_errors = 0;
        get_errors = 0;
        wait_timeouts = 0;
        test_name = "reset";
        for (i = 0; i < ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_value[i] = '0;
        end
        repeat (8) @(posedge clk);
        srst <= 1'b0;

        // Dense keys so gets often find an entry
        test_name = "set_get";
        repeat (60) begin
            k = KEY_WID'(rand_below(16));
            if (rand_below(2) == 0) begin
                set_entry(k, rand_value());
            end else begin
                get_entry(k);
            end
        end

        test_name = "replace_unset";
        repeat (30) begin
            k = KEY_WID'(rand_below(16));
            if (rand_below(2) == 0) begin
                replace_entry(k, rand_value());
            end else begin
                unset_entry(k);
            end
            get_entry(k);
        end

        test_name = "get_next";
        clear_table();
        get_next_entry(KEY_WID'(ENTRIES - 1));
        get_next_entry(KEY_WID'(ENTRIES - 10));
        repeat (20) begin
            base = rand_below(41);
            set_entry(KEY_WID'(base + 1 + rand_below(SAFE_SCAN)), rand_value());
            get_next_entry(KEY_WID'(base));
        end

        test_name = "random_mix";
        repeat (120) begin
            op = rand_below(16);
            k = rand_key();
            case (op)
                0: clear_table();
                1: send_nop(k);
                2: send_undefined(k);
                3, 4, 5: set_entry(k, rand_value());
                6, 7, 8: get_entry(k);
                9, 10: replace_entry(k, rand_value());
                11: unset_entry(k);
                default: get_next_entry(k);
            endcase
        end

        test_name = "clear";
        repeat (8) set_entry(rand_key(), rand_value());
        clear_table();
        for (i = 0; i < ENTRIES; i++) begin
            get_entry(KEY_WID'(i));
        end

        // Empty span of 62 entries above key 1
        test_name = "timeout";
        set_entry(KEY_WID'(1), rand_value());
        get_next_entry(KEY_WID'(1));
        set_entry(KEY_WID'(0), rand_value());
        get_next_entry(KEY_WID'(0));

        // Both commands carry the key and a new value of the entry they must leave alone
        test_name = "nop_undefined";
        set_entry(KEY_WID'(5), rand_value());
        send_nop(KEY_WID'(5));
        get_entry(KEY_WID'(5));
        send_undefined(KEY_WID'(5));
        get_entry(KEY_WID'(5));

        finish_run();
    end

endmodule : db_subsystem_tb

//--- db_subsystem.f
hw/db_pkg.sv
hw/db_peripheral.sv
hw/db_store.sv
hw/db_subsystem.sv
tb/db_subsystem_assertions.sv
tb/db_subsystem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the key-value table testbench with Verilator and run it.
# Exit status is zero only when the pass message appears in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module db_subsystem_tb \
    -f db_subsystem.f \
    -o db_subsystem_sim \
    && ./obj_dir/db_subsystem_sim | tee /dev/stderr | grep -q "^Test passed$" \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }
